//--- Bender.yml
package:
  name: psg

sources:
  - common/psg_pkg.sv
  - common/voice_if.sv
  - hdl/dpram.sv
  - psg/psg_sequencer.sv
  - psg/psg_voice.sv
  - psg/psg_mixer.sv
  - psg/psg_top.sv
  - target: test
    files:
      - bench/psg_checker.sv
      - bench/tb_psg.sv

//--- bench/psg_checker.sv
// Model assumes attribute writes only between frames; arrays start at zero like the DUT RAMs
module psg_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  psg_pkg::attr_addr_t  attr_addr,
    input  psg_pkg::attr_byte_t  attr_wrdata,
    input  logic                 attr_write,
    input  logic                 next_sample,
    input  psg_pkg::audio_t      left_audio,
    input  psg_pkg::audio_t      right_audio,
    output int                   error_count,
    output int                   check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    psg_pkg::attr_byte_t attr_mem [64];
    psg_pkg::phase_t     phase_mem [16];
    psg_pkg::wave_t      noise_mem [16];
    logic [15:0]         noise_lfsr;
    logic                busy;
    logic                publish_due;
    logic                check_due;
    int                  frame_cycle;
    int                  left_sum;
    int                  right_sum;
    int                  left_pub;
    int                  right_pub;
    psg_pkg::audio_t     left_seen;
    psg_pkg::audio_t     right_seen;

    initial begin
        for (int i = 0; i < 64; i++) begin
            attr_mem[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            phase_mem[i] = '0;
            noise_mem[i] = '0;
        end
        error_count = 0;
        check_count = 0;
    end

    // One voice of the model, evaluated on its calc edge
    task automatic calc_voice(input int v);
        psg_pkg::freq_t     freq;
        psg_pkg::volume_t   vol;
        psg_pkg::waveform_t wf;
        psg_pkg::phase_t    ph;
        psg_pkg::phase_t    next_ph;
        psg_pkg::wave_t     wave;
        int                 level;
        freq = {attr_mem[4*v+1], attr_mem[4*v]};
        vol  = attr_mem[4*v+2][5:0];
        wf   = attr_mem[4*v+3][7:6];
        ph   = phase_mem[v];
        case (wf)
            psg_pkg::wave_pulse:    wave = (ph[16:10] <= {1'b0, attr_mem[4*v+3][5:0]}) ? '1 : '0;
            psg_pkg::wave_saw:      wave = ph[16:7];
            psg_pkg::wave_triangle: wave = ph[16] ? ~ph[15:6] : ph[15:6];
            default:                wave = noise_mem[v];
        endcase
        // Offset binary centred on 512
        level = (int'(wave) - 512) * int'(psg_pkg::volume_gain(vol));
        if (attr_mem[4*v+2][6]) begin
            left_sum += level;
        end
        if (attr_mem[4*v+2][7]) begin
            right_sum += level;
        end
        next_ph = (vol == '0) ? '0 : ph + freq;
        if (ph[16] && !next_ph[16]) begin
            noise_mem[v] = noise_lfsr[9:0];
        end
        phase_mem[v] = next_ph;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            noise_lfsr  = 16'd1;
            busy        = 1'b0;
            publish_due = 1'b0;
            check_due   = 1'b0;
            frame_cycle = 0;
            left_sum    = 0;
            right_sum   = 0;
            left_seen   = '0;
            right_seen  = '0;
        end else begin
            if (attr_write) begin
                attr_mem[attr_addr] = attr_wrdata;
            end

            ////////////////////////////////
            // Output checks
            ////////////////////////////////
            if (check_due) begin
                check_count++;
                check_due = 1'b0;
                if (int'(left_audio) != left_pub) begin
                    $display("[ERROR] %0d ns: left_audio %0d, expected %0d",
                             $time, left_audio, left_pub);
                    error_count++;
                end
                if (int'(right_audio) != right_pub) begin
                    $display("[ERROR] %0d ns: right_audio %0d, expected %0d",
                             $time, right_audio, right_pub);
                    error_count++;
                end
            end else if (left_audio !== left_seen || right_audio !== right_seen) begin
                $display("Audio outputs changed at %0d ns outside a publish point", $time);
                error_count++;
            end
            left_seen  = left_audio;
            right_seen = right_audio;

            ////////////////////////////////
            // Frame model
            ////////////////////////////////
            if (busy) begin
                frame_cycle++;
                if (frame_cycle % 6 == 0) begin
                    calc_voice(frame_cycle / 6 - 1);
                end
                if (frame_cycle == 96) begin
                    busy        = 1'b0;
                    publish_due = 1'b1;
                end
            end else begin
                // First idle edge publishes, then a new frame may start
                if (publish_due) begin
                    left_pub    = left_sum;
                    right_pub   = right_sum;
                    publish_due = 1'b0;
                    check_due   = 1'b1;
                end
                if (next_sample) begin
                    busy        = 1'b1;
                    frame_cycle = 0;
                    left_sum    = 0;
                    right_sum   = 0;
                end
            end
            noise_lfsr = {noise_lfsr[14:0],
                          noise_lfsr[1] ^ noise_lfsr[2] ^ noise_lfsr[4] ^ noise_lfsr[15]};
        end
    end

endmodule

//--- bench/tb_psg.sv
// Drives 60 frames with attribute writes between frames; extra next_sample pulses hit mid-frame
module tb_psg;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_frames = 60;
    localparam int max_cycles = num_frames * 200;

    logic                clk;
    logic                rst;
    psg_pkg::attr_addr_t attr_addr;
    psg_pkg::attr_byte_t attr_wrdata;
    logic                attr_write;
    logic                next_sample;
    psg_pkg::audio_t     left_audio;
    psg_pkg::audio_t     right_audio;
    int                  error_count;
    int                  check_count;
    int                  cycle_count;
    logic [31:0]         rand_state;

    psg_top DUT (
        .clk         (clk),
        .rst         (rst),
        .attr_addr   (attr_addr),
        .attr_wrdata (attr_wrdata),
        .attr_write  (attr_write),
        .next_sample (next_sample),
        .left_audio  (left_audio),
        .right_audio (right_audio)
    );

    psg_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .attr_addr   (attr_addr),
        .attr_wrdata (attr_wrdata),
        .attr_write  (attr_write),
        .next_sample (next_sample),
        .left_audio  (left_audio),
        .right_audio (right_audio),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            rand_state = lfsr_next(rand_state);
            value = {value[30:0], rand_state[31]};
        end
    endtask

    task automatic write_byte(input psg_pkg::attr_addr_t addr, input psg_pkg::attr_byte_t data);
        @(posedge clk);
        attr_addr   <= addr;
        attr_wrdata <= data;
        attr_write  <= 1'b1;
        @(posedge clk);
        attr_write  <= 1'b0;
    endtask

    // Publish lands 97 cycles after the accepting edge, so 100 cycles covers the check
    task automatic run_frame(input logic disturb);
        logic [31:0] offset;
        random_bits(6, offset);
        offset = offset + 10;
        @(posedge clk);
        next_sample <= 1'b1;
        @(posedge clk);
        next_sample <= 1'b0;
        for (int i = 1; i <= 100; i++) begin
            @(posedge clk);
            next_sample <= disturb && (i == offset || i == offset + 12);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] count;
        rand_state  = 32'h77c533cd;
        cycle_count = 0;
        rst         = 1'b1;
        attr_addr   = '0;
        attr_wrdata = '0;
        attr_write  = 1'b0;
        next_sample = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // All voices silent
        run_frame(1'b0);

        for (int a = 0; a < 64; a++) begin
            random_bits(8, data);
            write_byte(psg_pkg::attr_addr_t'(a), data[7:0]);
        end

        for (int f = 1; f < num_frames; f++) begin
            random_bits(3, count);
            for (int w = 0; w < int'(count) + 2; w++) begin
                random_bits(6, addr);
                random_bits(8, data);
                write_byte(addr[5:0], data[7:0]);
            end
            // Mute one voice now and then, keeping random enables
            if (f % 5 == 0) begin
                random_bits(4, addr);
                random_bits(2, data);
                write_byte({addr[3:0], 2'd2}, {data[1:0], 6'd0});
            end
            run_frame(f % 3 == 0);
        end

        repeat (2) @(posedge clk);
        if (check_count != num_frames) begin
            $display("Only %0d of %0d frames reached a publish check", check_count, num_frames);
        end
        $display("Publish checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count == num_frames) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- common/psg_pkg.sv
// Shared PSG types; voice count is fixed at 16 and each voice uses four attribute bytes
package psg_pkg;

    //////////////////////////////
    // Widths with a meaning
    //////////////////////////////

    typedef logic [3:0]         channel_t;
    // Upper four bits voice, lower two bits byte
    typedef logic [5:0]         attr_addr_t;
    typedef logic [7:0]         attr_byte_t;
    typedef logic [15:0]        freq_t;
    typedef logic [5:0]         volume_t;
    typedef logic [5:0]         pulsewidth_t;
    typedef logic [1:0]         waveform_t;
    typedef logic [16:0]        phase_t;
    typedef logic [9:0]         wave_t;
    typedef logic [9:0]         gain_t;
    typedef logic signed [18:0] scaled_t;
    typedef logic signed [22:0] audio_t;

    // Sequencer states
    typedef enum logic [1:0] {
        idle,
        fetch,
        calc
    } seq_state_t;

    // Waveform select codes
    localparam waveform_t wave_pulse    = 2'd0;
    localparam waveform_t wave_saw      = 2'd1;
    localparam waveform_t wave_triangle = 2'd2;
    localparam waveform_t wave_noise    = 2'd3;

    //////////////////////////////
    // Volume to gain
    //////////////////////////////

    // 0.5 dB per step, code 63 is unity (512)
    localparam gain_t gain_table [64] = '{
        10'd0,   10'd14,  10'd15,  10'd16,  10'd16,  10'd17,  10'd19,  10'd20,
        10'd21,  10'd22,  10'd23,  10'd25,  10'd26,  10'd28,  10'd30,  10'd32,
        10'd33,  10'd35,  10'd38,  10'd40,  10'd42,  10'd45,  10'd47,  10'd50,
        10'd53,  10'd57,  10'd60,  10'd64,  10'd67,  10'd71,  10'd76,  10'd80,
        10'd85,  10'd90,  10'd95,  10'd101, 10'd107, 10'd114, 10'd120, 10'd128,
        10'd135, 10'd143, 10'd152, 10'd161, 10'd170, 10'd181, 10'd191, 10'd203,
        10'd215, 10'd228, 10'd241, 10'd256, 10'd271, 10'd287, 10'd304, 10'd322,
        10'd341, 10'd362, 10'd383, 10'd406, 10'd430, 10'd456, 10'd483, 10'd512
    };

    function automatic gain_t volume_gain(input volume_t volume);
        return gain_table[volume];
    endfunction

endpackage

//--- common/voice_if.sv
// Attributes of the voice being processed; fields are only meaningful during calc
interface voice_if;

    psg_pkg::channel_t    channel;
    psg_pkg::freq_t       freq;
    psg_pkg::volume_t     volume;
    logic                 left_en;
    logic                 right_en;
    psg_pkg::pulsewidth_t pulsewidth;
    psg_pkg::waveform_t   waveform;
    // One cycle per voice
    logic                 calc;

    modport seq (
        output channel, freq, volume, left_en, right_en, pulsewidth, waveform, calc
    );

    modport voice (
        input channel, freq, volume, pulsewidth, waveform, calc
    );

    modport mix (
        input left_en, right_en, calc
    );

endinterface

//--- hdl/dpram.sv
// Single clock RAM; read data lags the address by one cycle, contents start at zero
module dpram #(
    parameter int addr_width = 6,
    parameter int data_width = 8
) (
    input  logic                  clk,
    input  logic [addr_width-1:0] rd_addr,
    output logic [data_width-1:0] rd_data,
    input  logic [addr_width-1:0] wr_addr,
    input  logic [data_width-1:0] wr_data,
    input  logic                  wr_en
);

    logic [data_width-1:0] mem [2**addr_width];

    // Power-up contents, all voices silent
    initial begin
        for (int i = 0; i < 2**addr_width; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

//--- psg/psg_mixer.sv
// Stereo sum of one frame; outputs follow the accumulators only while the sequencer is idle
module psg_mixer (
    input  logic              clk,
    input  logic              rst,
    input  logic              frame_start,
    input  logic              idle,
    voice_if.mix              bus,
    input  psg_pkg::scaled_t  scaled,
    output psg_pkg::audio_t   left_audio,
    output psg_pkg::audio_t   right_audio
);

    psg_pkg::audio_t left_acc;
    psg_pkg::audio_t right_acc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            left_acc    <= '0;
            right_acc   <= '0;
            left_audio  <= '0;
            right_audio <= '0;
        end else begin
            if (frame_start) begin
                left_acc  <= '0;
                right_acc <= '0;
            end else if (bus.calc) begin
                // Each side only sums voices routed to it
                if (bus.left_en) begin
                    left_acc <= left_acc + scaled;
                end
                if (bus.right_en) begin
                    right_acc <= right_acc + scaled;
                end
            end

            // Publish point, first idle edge after voice 15
            if (idle) begin
                left_audio  <= left_acc;
                right_audio <= right_acc;
            end
        end
    end

endmodule

//--- psg/psg_sequencer.sv
// Walks all 16 voices per frame, six cycles each; next_sample is ignored while a frame runs
module psg_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   next_sample,
    output psg_pkg::attr_addr_t    rd_addr,
    input  psg_pkg::attr_byte_t    rd_data,
    output logic                   frame_start,
    output logic                   idle,
    voice_if.seq                   bus
);

    psg_pkg::seq_state_t state;
    psg_pkg::channel_t   channel;
    logic [2:0]          byte_cnt;
    logic [31:0]         attr_word;

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= psg_pkg::idle;
            channel  <= '0;
            byte_cnt <= '0;
        end else begin
            case (state)
                psg_pkg::idle: begin
                    if (next_sample) begin
                        state    <= psg_pkg::fetch;
                        channel  <= '0;
                        byte_cnt <= '0;
                    end
                end

                psg_pkg::fetch: begin
                    // Stale byte first, then bytes 0 to 3
                    if (byte_cnt == 3'd4) begin
                        state    <= psg_pkg::calc;
                        byte_cnt <= '0;
                    end else begin
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                end

                psg_pkg::calc: begin
                    channel <= channel + 4'd1;
                    if (channel == 4'd15) begin
                        state <= psg_pkg::idle;
                    end else begin
                        state <= psg_pkg::fetch;
                    end
                end

                default: begin
                    state <= psg_pkg::idle;
                end
            endcase
        end
    end

    // Address leads the shift by one cycle because of the registered read
    assign rd_addr = {channel, byte_cnt[1:0]};

    // Bytes arrive least significant first
    always_ff @(posedge clk) begin
        if (state == psg_pkg::fetch) begin
            attr_word <= {rd_data, attr_word[31:8]};
        end
    end

    assign frame_start = (state == psg_pkg::idle) && next_sample;
    assign idle        = (state == psg_pkg::idle);

    //////////////////////////////
    // Voice bus
    //////////////////////////////

    assign bus.channel    = channel;
    assign bus.freq       = attr_word[15:0];
    assign bus.volume     = attr_word[21:16];
    assign bus.left_en    = attr_word[22];
    assign bus.right_en   = attr_word[23];
    assign bus.pulsewidth = attr_word[29:24];
    assign bus.waveform   = attr_word[31:30];
    assign bus.calc       = (state == psg_pkg::calc);

    // Assertions

    a_byte_cnt_range: assert property (
        @(posedge clk) disable iff (rst) byte_cnt <= 3'd4
    );

    // Calc comes right after the last fetch cycle and lasts one cycle
    a_calc_single: assert property (
        @(posedge clk) disable iff (rst)
        bus.calc |-> $past(state == psg_pkg::fetch && byte_cnt == 3'd4) ##1 !bus.calc
    );

    // A frame lasts 96 cycles before idle returns
    a_frame_length: assert property (
        @(posedge clk) disable iff (rst)
        frame_start |=> !idle [*96] ##1 idle
    );

endmodule

//--- psg/psg_top.sv
// 16-voice PSG; next_sample must come from a sample-rate divider, output updates 97 cycles later
module psg_top (
    input  logic                 clk,
    input  logic                 rst,
    input  psg_pkg::attr_addr_t  attr_addr,
    input  psg_pkg::attr_byte_t  attr_wrdata,
    input  logic                 attr_write,
    input  logic                 next_sample,
    output psg_pkg::audio_t      left_audio,
    output psg_pkg::audio_t      right_audio
);

    psg_pkg::attr_addr_t rd_addr;
    psg_pkg::attr_byte_t rd_data;
    logic                frame_start;
    logic                idle;
    psg_pkg::scaled_t    scaled;

    voice_if bus ();

    // Host side write, sequencer side read
    dpram #(
        .addr_width (6),
        .data_width (8)
    ) attr_ram (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_addr (attr_addr),
        .wr_data (attr_wrdata),
        .wr_en   (attr_write)
    );

    psg_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .next_sample (next_sample),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .frame_start (frame_start),
        .idle        (idle),
        .bus         (bus.seq)
    );

    psg_voice u_voice (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus.voice),
        .scaled (scaled)
    );

    psg_mixer u_mixer (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .idle        (idle),
        .bus         (bus.mix),
        .scaled      (scaled),
        .left_audio  (left_audio),
        .right_audio (right_audio)
    );

endmodule

//--- psg/psg_voice.sv
// Voice datapath; phase and noise live in a 16-entry RAM, written back one edge after calc
module psg_voice (
    input  logic              clk,
    input  logic              rst,
    voice_if.voice            bus,
    output psg_pkg::scaled_t  scaled
);

    logic [15:0]          lfsr;
    logic [26:0]          work_rd;
    logic [26:0]          work_wr;
    logic                 wr_en;
    psg_pkg::channel_t    wr_idx;
    psg_pkg::wave_t       noise;
    psg_pkg::phase_t      phase;
    psg_pkg::phase_t      new_phase;
    psg_pkg::wave_t       new_noise;
    logic                 noise_latch;
    psg_pkg::wave_t       pulse_val;
    psg_pkg::wave_t       saw_val;
    psg_pkg::wave_t       tri_val;
    psg_pkg::wave_t       wave;
    logic signed [9:0]    signed_wave;
    psg_pkg::gain_t       gain;

    //////////////////////////////
    // Noise source
    //////////////////////////////

    // Free running from reset, taps 15, 4, 2, 1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= 16'd1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[1] ^ lfsr[2] ^ lfsr[4] ^ lfsr[15]};
        end
    end

    //////////////////////////////
    // Working RAM
    //////////////////////////////

    dpram #(
        .addr_width ($bits(psg_pkg::channel_t)),
        .data_width ($bits(psg_pkg::wave_t) + $bits(psg_pkg::phase_t))
    ) work_ram (
        .clk     (clk),
        .rd_addr (bus.channel),
        .rd_data (work_rd),
        .wr_addr (wr_idx),
        .wr_data (work_wr),
        .wr_en   (wr_en)
    );

    assign noise = work_rd[26:17];
    assign phase = work_rd[16:0];

    // Silent voice restarts from zero
    assign new_phase   = (bus.volume != '0) ? phase + bus.freq : '0;
    assign noise_latch = phase[16] && !new_phase[16];
    assign new_noise   = noise_latch ? lfsr[9:0] : noise;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= bus.calc;
        end
    end

    // Write data and index are captured on the calc edge
    always_ff @(posedge clk) begin
        wr_idx  <= bus.channel;
        work_wr <= {new_noise, new_phase};
    end

    //////////////////////////////
    // Waveform and volume
    //////////////////////////////

    assign pulse_val = (phase[16:10] > {1'b0, bus.pulsewidth}) ? 10'h000 : 10'h3ff;
    assign saw_val   = phase[16:7];
    assign tri_val   = phase[16] ? ~phase[15:6] : phase[15:6];

    always_comb begin
        case (bus.waveform)
            psg_pkg::wave_pulse:    wave = pulse_val;
            psg_pkg::wave_saw:      wave = saw_val;
            psg_pkg::wave_triangle: wave = tri_val;
            default:                wave = noise;
        endcase
    end

    // Offset binary to two's complement
    assign signed_wave = {~wave[9], wave[8:0]};
    assign gain        = psg_pkg::volume_gain(bus.volume);
    assign scaled      = signed_wave * $signed({1'b0, gain});

    // Write-back targets the voice just calculated, one behind the voice being read
    a_wb_after_calc: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (bus.channel == wr_idx + 4'd1)
    );

endmodule

//--- vlog.f
common/psg_pkg.sv
common/voice_if.sv
hdl/dpram.sv
psg/psg_sequencer.sv
psg/psg_voice.sv
psg/psg_mixer.sv
psg/psg_top.sv
bench/psg_checker.sv
bench/tb_psg.sv
